// ==== list.f ====
+incdir+src
src/core_complex_pkg.sv
src/mc_link_fifo.sv
src/mc_fwd_router.sv
src/mc_rev_arbiter.sv
src/core_endpoint.sv
src/core_complex.sv
test/core_complex_checker.sv
test/tb_core_complex.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_core_complex -o tb_core_complex
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_core_complex > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
exit 1

// ==== src/core_complex.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module core_complex
  (input                                  clk_i
  ,input                                  rst_n_i

  ,input                                  fwd_v_i
  ,input  core_complex_pkg::mc_fwd_pkt_t  fwd_data_i
  ,output logic                           fwd_token_o

  ,output logic                           rev_v_o
  ,output core_complex_pkg::mc_rev_pkt_t  rev_data_o
  ,input                                  rev_token_i
  );

  logic                          req_v;
  logic                          req_ready;
  core_complex_pkg::mc_fwd_pkt_t req_pkt;

  logic [`MC_NUM_ENDPOINTS-1:0]  ep_v;
  logic [`MC_NUM_ENDPOINTS-1:0]  ep_ready;
  core_complex_pkg::mc_fwd_pkt_t ep_pkt;

  logic [`MC_NUM_ENDPOINTS-1:0]  rsp_v;
  logic [`MC_NUM_ENDPOINTS-1:0]  rsp_ready;
  core_complex_pkg::mc_rev_pkt_t [`MC_NUM_ENDPOINTS-1:0] rsp_pkt;

  // host forward link enters at the west corner
  mc_link_fifo fifo
    (.clk_i      (clk_i      )
    ,.rst_n_i    (rst_n_i    )
    ,.fwd_v_i    (fwd_v_i    )
    ,.fwd_data_i (fwd_data_i )
    ,.fwd_token_o(fwd_token_o)
    ,.req_v_o    (req_v      )
    ,.req_pkt_o  (req_pkt    )
    ,.req_ready_i(req_ready  )
    );

  mc_fwd_router router
    (.req_v_i    (req_v    )
    ,.req_pkt_i  (req_pkt  )
    ,.req_ready_o(req_ready)
    ,.ep_v_o     (ep_v     )
    ,.ep_pkt_o   (ep_pkt   )
    ,.ep_ready_i (ep_ready )
    );

  // low x coordinates form the west group and high ones the east group
  for (genvar i = 0; i < `MC_NUM_ENDPOINTS; i++)
  begin: ep
    core_endpoint #(.EP_X(core_complex_pkg::mc_x_cord_t'(i))) tile
      (.clk_i      (clk_i       )
      ,.rst_n_i    (rst_n_i     )
      ,.ep_v_i     (ep_v     [i])
      ,.ep_pkt_i   (ep_pkt      )
      ,.ep_ready_o (ep_ready [i])
      ,.rsp_v_o    (rsp_v    [i])
      ,.rsp_pkt_o  (rsp_pkt  [i])
      ,.rsp_ready_i(rsp_ready[i])
      );
  end

  mc_rev_arbiter arbiter
    (.clk_i      (clk_i      )
    ,.rst_n_i    (rst_n_i    )
    ,.rsp_v_i    (rsp_v      )
    ,.rsp_pkt_i  (rsp_pkt    )
    ,.rsp_ready_o(rsp_ready  )
    ,.rev_v_o    (rev_v_o    )
    ,.rev_data_o (rev_data_o )
    ,.rev_token_i(rev_token_i)
    );

endmodule

// ==== src/core_complex_defines.svh ====
`ifndef CORE_COMPLEX_DEFINES_SVH
`define CORE_COMPLEX_DEFINES_SVH

// packet field widths
`define MC_DATA_WIDTH    32
`define MC_ADDR_WIDTH    4
`define MC_X_CORD_WIDTH  2

// endpoints 0 and 1 sit on the west side, 2 and 3 on the east side
`define MC_NUM_ENDPOINTS 4

// host starts with one forward credit per buffer entry
`define MC_FWD_FIFO_ELS  4

// reverse credits held by the fabric out of reset
`define MC_REV_CREDITS   4

`endif

// ==== src/core_complex_pkg.sv ====
`include "core_complex_defines.svh"

package core_complex_pkg;

  typedef logic [`MC_DATA_WIDTH-1:0]   mc_data_t;
  typedef logic [`MC_ADDR_WIDTH-1:0]   mc_addr_t;
  typedef logic [`MC_X_CORD_WIDTH-1:0] mc_x_cord_t;

  typedef enum logic [0:0]
  {
    MC_OP_LOAD  = 1'b0
   ,MC_OP_STORE = 1'b1
  } mc_op_e;

  // host request, steered by x_cord
  typedef struct packed
  {
    mc_op_e     op;
    mc_x_cord_t x_cord;
    mc_addr_t   addr;
    mc_data_t   data;
  } mc_fwd_pkt_t;

  // x_cord names the endpoint that answered
  typedef struct packed
  {
    mc_op_e     op;
    mc_x_cord_t x_cord;
    mc_data_t   data;
  } mc_rev_pkt_t;

  typedef enum logic
  {
    EP_IDLE
   ,EP_RESP
  } ep_state_e;

endpackage

// ==== src/core_endpoint.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module core_endpoint
  #(parameter core_complex_pkg::mc_x_cord_t EP_X = '0)
  (input                                  clk_i
  ,input                                  rst_n_i

  ,input                                  ep_v_i
  ,input  core_complex_pkg::mc_fwd_pkt_t  ep_pkt_i
  ,output logic                           ep_ready_o

  ,output logic                           rsp_v_o
  ,output core_complex_pkg::mc_rev_pkt_t  rsp_pkt_o
  ,input                                  rsp_ready_i
  );

  localparam int depth_lp = 1 << `MC_ADDR_WIDTH;

  core_complex_pkg::ep_state_e state_r;
  core_complex_pkg::mc_data_t  mem_r [depth_lp];

  logic accept;
  logic is_store;

  assign ep_ready_o = (state_r == core_complex_pkg::EP_IDLE);
  assign rsp_v_o    = (state_r == core_complex_pkg::EP_RESP);
  assign accept     = ep_v_i & ep_ready_o;
  assign is_store   = (ep_pkt_i.op == core_complex_pkg::MC_OP_STORE);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= core_complex_pkg::EP_IDLE;
      for (int i = 0; i < depth_lp; i++)
        mem_r[i] <= '0;
    end
    else
    begin
      case (state_r)
        core_complex_pkg::EP_IDLE:
          if (accept)
            state_r <= core_complex_pkg::EP_RESP;
        core_complex_pkg::EP_RESP:
          if (rsp_ready_i)
            state_r <= core_complex_pkg::EP_IDLE;
        default:
          state_r <= core_complex_pkg::EP_IDLE;
      endcase

      if (accept && is_store)
        mem_r[ep_pkt_i.addr] <= ep_pkt_i.data;
    end
  end

  // loads return the stored word, stores echo the written one
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rsp_pkt_o.op     <= ep_pkt_i.op;
      rsp_pkt_o.x_cord <= EP_X;
      rsp_pkt_o.data   <= is_store ? ep_pkt_i.data : mem_r[ep_pkt_i.addr];
    end
  end

  // the arbiter takes a response only from a tile that holds one
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_ready_i |-> (state_r == core_complex_pkg::EP_RESP))
    else $error("core_endpoint %0d: response taken outside EP_RESP", EP_X);

endmodule

// ==== src/mc_fwd_router.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module mc_fwd_router
  (input                                  req_v_i
  ,input  core_complex_pkg::mc_fwd_pkt_t  req_pkt_i
  ,output logic                           req_ready_o

  ,output logic [`MC_NUM_ENDPOINTS-1:0]   ep_v_o
  ,output core_complex_pkg::mc_fwd_pkt_t  ep_pkt_o
  ,input  [`MC_NUM_ENDPOINTS-1:0]         ep_ready_i
  );

  // every endpoint sees the head packet, only the addressed one sees valid
  assign ep_pkt_o = req_pkt_i;

  always_comb
  begin
    ep_v_o      = '0;
    req_ready_o = 1'b0;
    for (int i = 0; i < `MC_NUM_ENDPOINTS; i++)
    begin
      if (req_pkt_i.x_cord == core_complex_pkg::mc_x_cord_t'(i))
      begin
        ep_v_o[i]   = req_v_i;
        req_ready_o = ep_ready_i[i];
      end
    end

    // a valid head must name an existing endpoint
    assert ($onehot0(ep_v_o) && ((|ep_v_o) == req_v_i))
      else $error("mc_fwd_router: request x_cord %0d has no single target",
                  req_pkt_i.x_cord);
  end

endmodule

// ==== src/mc_link_fifo.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module mc_link_fifo
  (input                                  clk_i
  ,input                                  rst_n_i

  ,input                                  fwd_v_i
  ,input  core_complex_pkg::mc_fwd_pkt_t  fwd_data_i
  ,output logic                           fwd_token_o

  ,output logic                           req_v_o
  ,output core_complex_pkg::mc_fwd_pkt_t  req_pkt_o
  ,input                                  req_ready_i
  );

  localparam int els_lp       = `MC_FWD_FIFO_ELS;
  localparam int ptr_width_lp = (els_lp > 1) ? $clog2(els_lp) : 1;
  localparam int cnt_width_lp = $clog2(els_lp + 1);

  core_complex_pkg::mc_fwd_pkt_t mem_r [els_lp];

  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push;
  logic                    pop;

  function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(els_lp - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // every valid beat on the link is a push
  assign push = fwd_v_i;
  assign pop  = req_v_o & req_ready_i;

  assign req_v_o   = (count_r != '0);
  assign req_pkt_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r    <= '0;
      rd_ptr_r    <= '0;
      count_r     <= '0;
      fwd_token_o <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= ptr_next(wr_ptr_r);
      if (pop)
        rd_ptr_r <= ptr_next(rd_ptr_r);
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
      // one credit back to the host per freed entry
      fwd_token_o <= pop;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= fwd_data_i;
  end

  // host credit rule keeps pushes away from a full buffer
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fwd_v_i |-> (count_r != cnt_width_lp'(els_lp)))
    else $error("mc_link_fifo: push while full");

endmodule

// ==== src/mc_rev_arbiter.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module mc_rev_arbiter
  (input                                  clk_i
  ,input                                  rst_n_i

  ,input  [`MC_NUM_ENDPOINTS-1:0]         rsp_v_i
  ,input  core_complex_pkg::mc_rev_pkt_t [`MC_NUM_ENDPOINTS-1:0] rsp_pkt_i
  ,output logic [`MC_NUM_ENDPOINTS-1:0]   rsp_ready_o

  ,output logic                           rev_v_o
  ,output core_complex_pkg::mc_rev_pkt_t  rev_data_o
  ,input                                  rev_token_i
  );

  localparam int num_lp          = `MC_NUM_ENDPOINTS;
  localparam int idx_width_lp    = (num_lp > 1) ? $clog2(num_lp) : 1;
  localparam int credit_width_lp = $clog2(`MC_REV_CREDITS + 1);

  logic [credit_width_lp-1:0] credit_r;
  logic [idx_width_lp-1:0]    rr_ptr_r;
  logic [idx_width_lp-1:0]    gnt_idx;
  logic                       gnt_found;
  logic                       gnt_v;

  // the waiting endpoint closest after the pointer wins
  always_comb
  begin
    gnt_found = 1'b0;
    gnt_idx   = rr_ptr_r;
    for (int k = num_lp - 1; k >= 0; k--)
    begin
      int cand;
      cand = (int'(rr_ptr_r) + k) % num_lp;
      if (rsp_v_i[cand])
      begin
        gnt_found = 1'b1;
        gnt_idx   = idx_width_lp'(cand);
      end
    end

    gnt_v = gnt_found && (credit_r != '0);

    for (int i = 0; i < num_lp; i++)
      rsp_ready_o[i] = gnt_v && (gnt_idx == idx_width_lp'(i));
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      credit_r <= credit_width_lp'(`MC_REV_CREDITS);
      rr_ptr_r <= '0;
      rev_v_o  <= 1'b0;
    end
    else
    begin
      credit_r <= credit_r - credit_width_lp'(gnt_v) + credit_width_lp'(rev_token_i);
      rev_v_o  <= gnt_v;
      if (gnt_v)
        rr_ptr_r <= (gnt_idx == idx_width_lp'(num_lp - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (gnt_v)
      rev_data_o <= rsp_pkt_i[gnt_idx];
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_o |-> ($past(credit_r) != '0))
    else $error("mc_rev_arbiter: reverse send without a credit");

  // host tokens never outnumber the packets it was sent
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_r <= credit_width_lp'(`MC_REV_CREDITS))
    else $error("mc_rev_arbiter: credit count %0d above limit", credit_r);

endmodule

// ==== test/core_complex_checker.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module core_complex_checker
  (input                                  clk_i
  ,input                                  rst_n_i
  ,input                                  fwd_v_i
  ,input  core_complex_pkg::mc_fwd_pkt_t  fwd_data_i
  ,input                                  fwd_token_i
  ,input                                  rev_v_i
  ,input  core_complex_pkg::mc_rev_pkt_t  rev_data_i
  ,input                                  rev_token_i
  ,output int                             err_count_o
  ,output int                             rsp_count_o
  ,output int                             pending_o
  );

  localparam int words_lp = 1 << `MC_ADDR_WIDTH;

  core_complex_pkg::mc_data_t    model_mem [`MC_NUM_ENDPOINTS][words_lp];
  core_complex_pkg::mc_rev_pkt_t expect_q  [`MC_NUM_ENDPOINTS][$];

  int err_count = 0;
  int rsp_count = 0;
  int pending   = 0;
  int req_count = 0;
  int tok_count = 0;
  int rev_held  = 0;

  assign err_count_o = err_count;
  assign rsp_count_o = rsp_count;
  assign pending_o   = pending;

  always @(posedge clk_i)
  begin
    core_complex_pkg::mc_rev_pkt_t exp_pkt;
    if (!rst_n_i)
    begin
      for (int e = 0; e < `MC_NUM_ENDPOINTS; e++)
      begin
        expect_q[e].delete();
        for (int a = 0; a < words_lp; a++)
          model_mem[e][a] = '0;
      end
      pending   = 0;
      req_count = 0;
      tok_count = 0;
      rev_held  = 0;
    end
    else
    begin
      // the model answers in request order per endpoint
      if (fwd_v_i)
      begin
        if (fwd_data_i.op == core_complex_pkg::MC_OP_STORE)
          model_mem[fwd_data_i.x_cord][fwd_data_i.addr] = fwd_data_i.data;
        exp_pkt.op     = fwd_data_i.op;
        exp_pkt.x_cord = fwd_data_i.x_cord;
        exp_pkt.data   = model_mem[fwd_data_i.x_cord][fwd_data_i.addr];
        expect_q[fwd_data_i.x_cord].push_back(exp_pkt);
        req_count++;
        pending++;
      end
      if (fwd_token_i)
      begin
        tok_count++;
        if (tok_count > req_count)
        begin
          $display("error at %0t: fwd_token_o returned a credit for no request", $time);
          err_count++;
        end
      end
      if (rev_v_i)
      begin
        rsp_count++;
        rev_held++;
        if (rev_held > `MC_REV_CREDITS)
        begin
          $display("error at %0t: rev_v_o sent a response without a credit", $time);
          err_count++;
        end
        if (expect_q[rev_data_i.x_cord].size() == 0)
        begin
          $display("error at %0t: response from endpoint %0d with no request outstanding",
                   $time, rev_data_i.x_cord);
          err_count++;
        end
        else
        begin
          exp_pkt = expect_q[rev_data_i.x_cord].pop_front();
          pending--;
          if (rev_data_i.op != exp_pkt.op)
          begin
            $display("error at %0t: rev_data_o.op (endpoint %0d) expected %0d got %0d",
                     $time, rev_data_i.x_cord, exp_pkt.op, rev_data_i.op);
            err_count++;
          end
          if (rev_data_i.data != exp_pkt.data)
          begin
            $display("error at %0t: rev_data_o.data (endpoint %0d) expected %h got %h",
                     $time, rev_data_i.x_cord, exp_pkt.data, rev_data_i.data);
            err_count++;
          end
        end
      end
      if (rev_token_i)
        rev_held--;
    end
  end

endmodule

// ==== test/tb_core_complex.sv ====
`timescale 1ns/1ps
`include "core_complex_defines.svh"

module tb_core_complex;

  localparam int timeout_lp = 2000;

  logic                          clk;
  logic                          rst_n;
  logic                          fwd_v;
  logic                          fwd_token;
  logic                          rev_v;
  logic                          rev_token;
  core_complex_pkg::mc_fwd_pkt_t fwd_data;
  core_complex_pkg::mc_rev_pkt_t rev_data;

  integer seed         = 99;
  int     sent_count   = 0;
  int     tok_count    = 0;
  int     rev_seen     = 0;
  int     rev_returned = 0;
  int     tb_errors    = 0;
  int     chk_errors;
  int     chk_rsp_count;
  int     chk_pending;
  bit     hold_rev     = 1'b0;
  bit     fast_rev     = 1'b1;
  bit     timed_out    = 1'b0;

  core_complex core_complex_inst
    (.clk_i      (clk      )
    ,.rst_n_i    (rst_n    )
    ,.fwd_v_i    (fwd_v    )
    ,.fwd_data_i (fwd_data )
    ,.fwd_token_o(fwd_token)
    ,.rev_v_o    (rev_v    )
    ,.rev_data_o (rev_data )
    ,.rev_token_i(rev_token)
    );

  core_complex_checker core_complex_checker_inst
    (.clk_i      (clk          )
    ,.rst_n_i    (rst_n        )
    ,.fwd_v_i    (fwd_v        )
    ,.fwd_data_i (fwd_data     )
    ,.fwd_token_i(fwd_token    )
    ,.rev_v_i    (rev_v        )
    ,.rev_data_i (rev_data     )
    ,.rev_token_i(rev_token    )
    ,.err_count_o(chk_errors   )
    ,.rsp_count_o(chk_rsp_count)
    ,.pending_o  (chk_pending  )
    );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (rst_n && fwd_token)
      tok_count++;
    if (rst_n && rev_v)
      rev_seen++;
  end

  // one falling edge, with a reverse token for a response seen earlier
  task automatic next_cycle();
    @(negedge clk);
    fwd_v     = 1'b0;
    rev_token = 1'b0;
    if (!hold_rev && (rev_returned < rev_seen) && (fast_rev || (($random(seed) & 3) == 0)))
    begin
      rev_token = 1'b1;
      rev_returned++;
    end
  endtask

  task automatic check_timeout(input int waited, input string what);
    if (waited >= timeout_lp && !timed_out)
    begin
      $display("timeout at %0t while waiting for %s", $time, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic apply_reset();
    next_cycle();
    rst_n = 1'b0;
    next_cycle();
    next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic settle(input int cycles);
    for (int i = 0; i < cycles; i++)
      next_cycle();
  endtask

  task automatic send_req(input core_complex_pkg::mc_op_e op, input int x,
                          input int addr, input int data);
    int waited;
    waited = 0;
    while (!timed_out && (`MC_FWD_FIFO_ELS + tok_count - sent_count) <= 0)
    begin
      next_cycle();
      waited++;
      check_timeout(waited, "a forward credit");
    end
    if (!timed_out)
    begin
      next_cycle();
      fwd_data.op     = op;
      fwd_data.x_cord = core_complex_pkg::mc_x_cord_t'(x);
      fwd_data.addr   = core_complex_pkg::mc_addr_t'(addr);
      fwd_data.data   = core_complex_pkg::mc_data_t'(data);
      fwd_v           = 1'b1;
      sent_count++;
    end
  endtask

  // a negative x picks a random endpoint
  task automatic send_random(input int x, input bit load_only);
    int a;
    int d;
    bit st;
    if (x < 0)
      x = $random(seed);
    a  = $random(seed);
    d  = $random(seed);
    st = (($random(seed) & 1) != 0) && !load_only;
    send_req(st ? core_complex_pkg::MC_OP_STORE : core_complex_pkg::MC_OP_LOAD, x, a, d);
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (!timed_out && (chk_pending != 0 || rev_returned != rev_seen))
    begin
      next_cycle();
      waited++;
      check_timeout(waited, "outstanding requests to drain");
    end
  endtask

  task automatic expect_count(input string name, input int exp_val, input int act_val);
    if (!timed_out && exp_val != act_val)
    begin
      $display("error at %0t: %s expected %0d got %0d", $time, name, exp_val, act_val);
      tb_errors++;
    end
  endtask

  task automatic report_test(input string name, input int base);
    $display("test %s finished with %0d errors", name, tb_errors + chk_errors - base);
  endtask

  initial
  begin
    int base;
    int mark;
    int start;
    int a;
    int d;
    rst_n     = 1'b0;
    fwd_v     = 1'b0;
    fwd_data  = '0;
    rev_token = 1'b0;
    apply_reset();

    base = tb_errors + chk_errors;
    settle(20);
    for (int i = 0; i < 8; i++)
      send_random(-1, 1'b1);
    wait_idle();
    report_test("after reset", base);

    base = tb_errors + chk_errors;
    for (int x = 0; x < `MC_NUM_ENDPOINTS; x++)
    begin
      a = $random(seed);
      d = $random(seed);
      send_req(core_complex_pkg::MC_OP_STORE, x, a, d);
      send_req(core_complex_pkg::MC_OP_LOAD, x, a, 0);
    end
    wait_idle();
    report_test("store then load", base);

    base     = tb_errors + chk_errors;
    fast_rev = 1'b0;
    for (int i = 0; i < 300; i++)
      send_random(-1, 1'b0);
    wait_idle();
    fast_rev = 1'b1;
    report_test("random traffic", base);

    // endpoints keep the responses that find no credit
    base     = tb_errors + chk_errors;
    hold_rev = 1'b1;
    mark     = rev_seen;
    for (int i = 0; i < 2 * `MC_REV_CREDITS; i++)
      send_random(i % `MC_NUM_ENDPOINTS, 1'b0);
    settle(40);
    expect_count("rev_v_o pulses with tokens held", `MC_REV_CREDITS, rev_seen - mark);
    hold_rev = 1'b0;
    wait_idle();
    expect_count("rev_v_o pulses after release", 2 * `MC_REV_CREDITS, rev_seen - mark);
    report_test("reverse back-pressure", base);

    base = tb_errors + chk_errors;
    apply_reset();
    mark  = tok_count;
    start = rev_seen;
    for (int i = 0; i < `MC_FWD_FIFO_ELS; i++)
      send_random(-1, 1'b0);
    wait_idle();
    expect_count("fwd_token_o pulses", `MC_FWD_FIFO_ELS, tok_count - mark);
    expect_count("rev_v_o pulses", `MC_FWD_FIFO_ELS, rev_seen - start);
    report_test("forward credits", base);

    $display("summary: %0d errors, %0d responses checked, %0d requests sent",
             tb_errors + chk_errors, chk_rsp_count, sent_count);
    if (!timed_out && (tb_errors + chk_errors) == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
